//--- lsu_isa_pkg.sv
package lsu_isa_pkg;

	// instruction field positions
	localparam int OP_HI = 31; // primary opcode
	localparam int OP_LO = 26;
	localparam int KIND_HI = 28; // low opcode bits double as load kind
	localparam int KIND_LO = 26;
	localparam int IMM_W = 16; // offset immediate, bits 15..0

	// loads
	localparam logic [5:0] OP_LB = 6'b100000;
	localparam logic [5:0] OP_LH = 6'b100001;
	localparam logic [5:0] OP_LWL = 6'b100010;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_LBU = 6'b100100;
	localparam logic [5:0] OP_LHU = 6'b100101;
	localparam logic [5:0] OP_LWR = 6'b100110;

	// stores, SWL/SWR not handled
	localparam logic [5:0] OP_SB = 6'b101000;
	localparam logic [5:0] OP_SH = 6'b101001;
	localparam logic [5:0] OP_SW = 6'b101011;

	// internal load kind, same coding as instr[28:26] of the load
	typedef enum logic [2:0] {
		LK_LB = 3'b000,
		LK_LH = 3'b001,
		LK_LWL = 3'b010,
		LK_LW = 3'b011,
		LK_LBU = 3'b100,
		LK_LHU = 3'b101,
		LK_LWR = 3'b110
	} load_kind_t;

endpackage

//--- lsu_mem_pkg.sv
package lsu_mem_pkg;

	localparam int LANES = 4; // bytes per RAM word
	localparam int BYTE_W = 8;

	// bit i enables lane i, lane 0 is bits 7..0 of the word
	typedef logic [LANES-1:0] byte_en_t;

	localparam byte_en_t BE_NONE = 4'b0000; // error requests
	localparam byte_en_t BE_LANE0 = 4'b0001; // shifted by offset for bytes
	localparam byte_en_t BE_LO_HALF = 4'b0011;
	localparam byte_en_t BE_HI_HALF = 4'b1100;
	localparam byte_en_t BE_ALL = 4'b1111;

endpackage

//--- load_align.sv
module load_align (
	input logic [31:0] mem_in, // raw RAM word
	input lsu_isa_pkg::load_kind_t kind,
	input lsu_mem_pkg::byte_en_t byteenable, // lanes to take
	output logic [31:0] mem_out // extended, register byte order
);

	localparam int BW = lsu_mem_pkg::BYTE_W;

	logic [BW-1:0] b0;
	logic [BW-1:0] b1;
	logic [BW-1:0] b2;
	logic [BW-1:0] b3;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	assign b0 = mem_in[0*BW +: BW];
	assign b1 = mem_in[1*BW +: BW];
	assign b2 = mem_in[2*BW +: BW];
	assign b3 = mem_in[3*BW +: BW];

	always_comb begin
		case (byteenable)
			4'b0010: byte_sel = b1;
			4'b0100: byte_sel = b2;
			4'b1000: byte_sel = b3;
			default: byte_sel = b0;
		endcase
		half_sel = byteenable[2] ? {b2, b3} : {b0, b1}; // lower lane is msb

		case (kind)
			lsu_isa_pkg::LK_LB: mem_out = {{24{byte_sel[7]}}, byte_sel};
			lsu_isa_pkg::LK_LBU: mem_out = {24'h0, byte_sel};
			lsu_isa_pkg::LK_LH: mem_out = {{16{half_sel[15]}}, half_sel};
			lsu_isa_pkg::LK_LHU: mem_out = {16'h0, half_sel};
			lsu_isa_pkg::LK_LWR: begin
				case (byteenable)
					4'b0001: mem_out = {24'h0, b0}; // counted from lane 0 up
					4'b0011: mem_out = {16'h0, b0, b1};
					4'b0111: mem_out = {8'h0, b0, b1, b2};
					default: mem_out = {b0, b1, b2, b3};
				endcase
			end
			lsu_isa_pkg::LK_LWL: begin
				case (byteenable)
					4'b1000: mem_out = {24'h0, b3}; // counted from lane 3 down
					4'b1100: mem_out = {16'h0, b3, b2};
					4'b1110: mem_out = {8'h0, b3, b2, b1};
					default: mem_out = {b3, b2, b1, b0};
				endcase
			end
			default: mem_out = {b0, b1, b2, b3}; // LW byte swap
		endcase
	end

endmodule

//--- lsu_decode.sv
module lsu_decode #(
	parameter int DEPTH = 256
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input logic [31:0] instr,
	input logic [31:0] base,
	input logic [31:0] wdata,
	output logic dec_valid,
	input logic dec_ready,
	output logic [$clog2(DEPTH)-1:0] dec_index,
	output lsu_mem_pkg::byte_en_t dec_be,
	output lsu_isa_pkg::load_kind_t dec_kind,
	output logic dec_store,
	output logic dec_err,
	output logic [31:0] dec_wdata
);

	localparam int IDX_W = $clog2(DEPTH);

	logic [5:0] opcode;
	logic [31:0] imm_ext;
	logic [31:0] addr;
	logic [1:0] offset;
	lsu_mem_pkg::byte_en_t be;
	logic is_store;
	logic bad;
	logic accept;

	assign opcode = instr[lsu_isa_pkg::OP_HI:lsu_isa_pkg::OP_LO];
	assign imm_ext = {{(32 - lsu_isa_pkg::IMM_W){instr[lsu_isa_pkg::IMM_W-1]}},
		instr[lsu_isa_pkg::IMM_W-1:0]};
	assign addr = base + imm_ext; // effective address
	assign offset = addr[1:0];

	always_comb begin
		be = lsu_mem_pkg::BE_NONE;
		is_store = 1'b0;
		bad = 1'b0;
		case (opcode)
			lsu_isa_pkg::OP_LB, lsu_isa_pkg::OP_LBU, lsu_isa_pkg::OP_SB: begin
				be = lsu_mem_pkg::BE_LANE0 << offset;
				is_store = (opcode == lsu_isa_pkg::OP_SB);
			end
			lsu_isa_pkg::OP_LH, lsu_isa_pkg::OP_LHU, lsu_isa_pkg::OP_SH: begin
				is_store = (opcode == lsu_isa_pkg::OP_SH);
				if (offset[0])
					bad = 1'b1; // odd halfword
				else
					be = offset[1] ? lsu_mem_pkg::BE_HI_HALF : lsu_mem_pkg::BE_LO_HALF;
			end
			lsu_isa_pkg::OP_LW, lsu_isa_pkg::OP_SW: begin
				is_store = (opcode == lsu_isa_pkg::OP_SW);
				if (offset != 2'd0)
					bad = 1'b1;
				else
					be = lsu_mem_pkg::BE_ALL;
			end
			lsu_isa_pkg::OP_LWL: be = lsu_mem_pkg::BE_ALL << offset; // lanes o..3
			lsu_isa_pkg::OP_LWR: be = lsu_mem_pkg::BE_ALL >> offset; // lanes 0..3-o
			default: bad = 1'b1; // unsupported opcode, SWL/SWR included
		endcase
		if (bad)
			be = lsu_mem_pkg::BE_NONE;
	end

	assign in_ready = !dec_valid || dec_ready; // slot empty or draining
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else if (in_ready)
			dec_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec_index <= addr[IDX_W+1:2]; // wraps modulo DEPTH
			dec_be <= be;
			dec_kind <= lsu_isa_pkg::load_kind_t'(instr[lsu_isa_pkg::KIND_HI:lsu_isa_pkg::KIND_LO]);
			dec_store <= is_store && !bad;
			dec_err <= bad;
			dec_wdata <= wdata;
		end
	end

endmodule

//--- lsu_mem_access.sv
module lsu_mem_access #(
	parameter int DEPTH = 256
) (
	input logic clk,
	input logic rst_n,
	input logic dec_valid,
	output logic dec_ready,
	input logic [$clog2(DEPTH)-1:0] dec_index,
	input lsu_mem_pkg::byte_en_t dec_be,
	input lsu_isa_pkg::load_kind_t dec_kind,
	input logic dec_store,
	input logic dec_err,
	input logic [31:0] dec_wdata,
	output logic mem_valid,
	input logic mem_ready,
	output logic [31:0] mem_word,
	output lsu_mem_pkg::byte_en_t mem_be,
	output lsu_isa_pkg::load_kind_t mem_kind,
	output logic mem_load,
	output logic mem_err
);

	logic [31:0] ram [DEPTH];
	logic [31:0] wr_word;
	logic advance;

	assign dec_ready = !mem_valid || mem_ready;
	assign advance = dec_valid && dec_ready;

	// register byte order to lanes, msb byte in lowest enabled lane
	always_comb begin
		case (dec_be)
			lsu_mem_pkg::BE_ALL:
				wr_word = {dec_wdata[7:0], dec_wdata[15:8], dec_wdata[23:16], dec_wdata[31:24]};
			lsu_mem_pkg::BE_LO_HALF, lsu_mem_pkg::BE_HI_HALF:
				wr_word = {2{dec_wdata[7:0], dec_wdata[15:8]}}; // same halfword in both halves
			default:
				wr_word = {lsu_mem_pkg::LANES{dec_wdata[7:0]}}; // byte into every lane
		endcase
	end

	always_ff @(posedge clk) begin
		if (advance && dec_store && !dec_err) begin
			for (int i = 0; i < lsu_mem_pkg::LANES; i++) begin
				if (dec_be[i])
					ram[dec_index][i*lsu_mem_pkg::BYTE_W +: lsu_mem_pkg::BYTE_W] <=
						wr_word[i*lsu_mem_pkg::BYTE_W +: lsu_mem_pkg::BYTE_W];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_valid <= 1'b0;
		else if (dec_ready)
			mem_valid <= dec_valid;
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			if (!dec_store && !dec_err)
				mem_word <= ram[dec_index]; // read only on advance, held while stalled
			mem_be <= dec_be;
			mem_kind <= dec_kind;
			mem_load <= !dec_store;
			mem_err <= dec_err;
		end
	end

endmodule

//--- lsu_result.sv
module lsu_result (
	input logic clk,
	input logic rst_n,
	input logic mem_valid,
	output logic mem_ready,
	input logic [31:0] mem_word,
	input lsu_mem_pkg::byte_en_t mem_be,
	input lsu_isa_pkg::load_kind_t mem_kind,
	input logic mem_load,
	input logic mem_err,
	output logic out_valid,
	input logic out_ready,
	output logic [31:0] rdata,
	output logic err
);

	logic [31:0] aligned;

	load_align u_align (
		.mem_in(mem_word),
		.kind(mem_kind),
		.byteenable(mem_be),
		.mem_out(aligned)
	);

	assign mem_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (mem_ready)
			out_valid <= mem_valid;
	end

	always_ff @(posedge clk) begin
		if (mem_valid && mem_ready) begin
			rdata <= (mem_load && !mem_err) ? aligned : 32'h0; // stores and errors read 0
			err <= mem_err;
		end
	end

endmodule

//--- mips_lsu.sv
module mips_lsu #(
	parameter int DEPTH = 256 // RAM words, power of two
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input logic [31:0] instr,
	input logic [31:0] base,
	input logic [31:0] wdata,
	output logic out_valid,
	input logic out_ready,
	output logic [31:0] rdata,
	output logic err
);

	localparam int IDX_W = $clog2(DEPTH);

	// decode -> memory access
	logic dec_valid;
	logic dec_ready;
	logic [IDX_W-1:0] dec_index;
	lsu_mem_pkg::byte_en_t dec_be;
	lsu_isa_pkg::load_kind_t dec_kind;
	logic dec_store;
	logic dec_err;
	logic [31:0] dec_wdata;

	// memory access -> result
	logic mem_valid;
	logic mem_ready;
	logic [31:0] mem_word;
	lsu_mem_pkg::byte_en_t mem_be;
	lsu_isa_pkg::load_kind_t mem_kind;
	logic mem_load;
	logic mem_err;

	lsu_decode #(
		.DEPTH(DEPTH)
	) u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.instr(instr),
		.base(base),
		.wdata(wdata),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_index(dec_index),
		.dec_be(dec_be),
		.dec_kind(dec_kind),
		.dec_store(dec_store),
		.dec_err(dec_err),
		.dec_wdata(dec_wdata)
	);

	lsu_mem_access #(
		.DEPTH(DEPTH)
	) u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_index(dec_index),
		.dec_be(dec_be),
		.dec_kind(dec_kind),
		.dec_store(dec_store),
		.dec_err(dec_err),
		.dec_wdata(dec_wdata),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_word(mem_word),
		.mem_be(mem_be),
		.mem_kind(mem_kind),
		.mem_load(mem_load),
		.mem_err(mem_err)
	);

	lsu_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_word(mem_word),
		.mem_be(mem_be),
		.mem_kind(mem_kind),
		.mem_load(mem_load),
		.mem_err(mem_err),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.rdata(rdata),
		.err(err)
	);

endmodule

//--- lsu_ref_model.svh
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

logic [7:0] ref_mem [int unsigned]; // byte address -> value, mirrors the RAM

// lane enables from the lane ranges, none when the request is an error
function automatic lsu_mem_pkg::byte_en_t expected_lanes(logic [5:0] op, logic [1:0] off);
	int lo;
	int hi;
	lsu_mem_pkg::byte_en_t be;
	lo = off;
	hi = -1; // empty range
	case (op)
		lsu_isa_pkg::OP_LB, lsu_isa_pkg::OP_LBU, lsu_isa_pkg::OP_SB:
			hi = off;
		lsu_isa_pkg::OP_LH, lsu_isa_pkg::OP_LHU, lsu_isa_pkg::OP_SH:
			if (!off[0])
				hi = off + 1;
		lsu_isa_pkg::OP_LW, lsu_isa_pkg::OP_SW:
			if (off == 2'd0)
				hi = lsu_mem_pkg::LANES - 1;
		lsu_isa_pkg::OP_LWL:
			hi = lsu_mem_pkg::LANES - 1; // lanes o..3
		lsu_isa_pkg::OP_LWR: begin
			lo = 0;
			hi = lsu_mem_pkg::LANES - 1 - off; // lanes 0..3-o
		end
		default:
			hi = -1; // not a supported opcode
	endcase
	for (int i = 0; i < lsu_mem_pkg::LANES; i++)
		be[i] = (i >= lo) && (i <= hi);
	return be;
endfunction

// one request against the model, in request order
function automatic void apply_request(input logic [31:0] instr, input logic [31:0] base,
		input logic [31:0] wdata, input int unsigned depth,
		output logic err, output logic [31:0] rdata);
	logic [31:0] addr;
	logic [5:0] op;
	lsu_mem_pkg::byte_en_t be;
	int unsigned waddr;
	int n;
	addr = base + {{16{instr[15]}}, instr[15:0]};
	op = instr[31:26];
	be = expected_lanes(op, addr[1:0]);
	waddr = ((addr >> 2) % depth) * lsu_mem_pkg::LANES;
	err = (be == lsu_mem_pkg::BE_NONE);
	rdata = 32'h0;
	n = $countones(be);
	if (err)
		return;
	if (op[3]) begin // stores, msb register byte into lowest enabled lane
		for (int i = 0; i < lsu_mem_pkg::LANES; i++) begin
			if (be[i]) begin
				n--;
				ref_mem[waddr + i] = wdata[n*8 +: 8];
			end
		end
		return;
	end
	if (op == lsu_isa_pkg::OP_LWL) begin
		for (int i = lsu_mem_pkg::LANES - 1; i >= 0; i--)
			if (be[i]) rdata = (rdata << 8) | ref_mem[waddr + i];
	end else begin
		for (int i = 0; i < lsu_mem_pkg::LANES; i++)
			if (be[i]) rdata = (rdata << 8) | ref_mem[waddr + i];
	end
	if (op == lsu_isa_pkg::OP_LB && rdata[7])
		rdata[31:8] = '1;
	if (op == lsu_isa_pkg::OP_LH && rdata[15])
		rdata[31:16] = '1;
endfunction

`endif

//--- mips_lsu_tb.sv
module mips_lsu_tb;

	localparam int DEPTH = 16; // small RAM so addresses get reused
	localparam int N_RAND = 400;
	localparam int LIMIT = N_RAND * 8 + 200; // cycles

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic [31:0] instr;
	logic [31:0] base;
	logic [31:0] wdata;
	logic out_valid;
	logic out_ready;
	logic [31:0] rdata;
	logic err;

	logic stall_en; // random out_ready back-pressure
	int cycles;
	int errors;
	int n_req;
	int n_resp;
	int lat;
	logic [31:0] exp_data_q[$];
	logic exp_err_q[$];
	string name_q[$];
	logic [5:0] ops [10];
	logic [5:0] bad_ops [4];
	logic [5:0] op;

	`include "lsu_ref_model.svh"

	mips_lsu #(
		.DEPTH(DEPTH)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.instr(instr),
		.base(base),
		.wdata(wdata),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.rdata(rdata),
		.err(err)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles with %0d of %0d responses received",
				cycles, n_resp, n_req);
			$display("Test FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		#1;
		out_ready = stall_en ? ($urandom_range(0, 3) != 0) : 1'b1; // low about a quarter
	end

	// transfer happens on the next rising edge, values are stable here
	always @(negedge clk) begin
		if (rst_n && out_valid && out_ready)
			check_response();
	end

	function automatic logic [31:0] mk_instr(logic [5:0] opc, logic [15:0] imm);
		return {opc, 10'h0, imm};
	endfunction

	task automatic check_response();
		logic e;
		logic [31:0] d;
		string name;
		n_resp++;
		if (exp_err_q.size() == 0) begin
			$display("response %0d arrived with no request pending", n_resp);
			errors++;
		end else begin
			e = exp_err_q.pop_front();
			d = exp_data_q.pop_front();
			name = name_q.pop_front();
			if (err !== e) begin
				$display("MISMATCH %s err expected %0b actual %0b", name, e, err);
				errors++;
			end
			if (rdata !== d) begin
				$display("MISMATCH %s rdata expected %h actual %h", name, d, rdata);
				errors++;
			end
		end
	endtask

	// called just after a rising edge, returns just after the accept edge
	task automatic send(input string name, input logic [31:0] i_instr,
			input logic [31:0] i_base, input logic [31:0] i_wdata);
		logic e;
		logic [31:0] d;
		in_valid = 1'b1;
		instr = i_instr;
		base = i_base;
		wdata = i_wdata;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk); // accept edge
		apply_request(i_instr, i_base, i_wdata, DEPTH, e, d);
		exp_err_q.push_back(e);
		exp_data_q.push_back(d);
		name_q.push_back(name);
		n_req++;
		#1;
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (n_resp != n_req) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // last transfer edge
		#1;
	endtask

	initial begin
		void'($urandom(32'hbb058e06));
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		instr = 32'h0;
		base = 32'h0;
		wdata = 32'h0;
		out_ready = 1'b1;
		stall_en = 1'b0;
		cycles = 0;
		errors = 0;
		n_req = 0;
		n_resp = 0;
		ops = '{lsu_isa_pkg::OP_LB, lsu_isa_pkg::OP_LH, lsu_isa_pkg::OP_LWL,
			lsu_isa_pkg::OP_LW, lsu_isa_pkg::OP_LBU, lsu_isa_pkg::OP_LHU,
			lsu_isa_pkg::OP_LWR, lsu_isa_pkg::OP_SB, lsu_isa_pkg::OP_SH, lsu_isa_pkg::OP_SW};
		bad_ops = '{6'b101010, 6'b101110, 6'b100111, 6'b001000}; // SWL, SWR, others
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int w = 0; w < DEPTH; w++) // RAM powers up unknown
			send("prefill", mk_instr(lsu_isa_pkg::OP_SW, 16'h0), w * 4, $urandom());

		send("sw word 3", mk_instr(lsu_isa_pkg::OP_SW, 16'd4), 32'd8, 32'h80ff7f81);
		send("lw word 3", mk_instr(lsu_isa_pkg::OP_LW, 16'd4), 32'd8, 32'h0);
		send("lb sign", mk_instr(lsu_isa_pkg::OP_LB, 16'd4), 32'd8, 32'h0);
		send("lbu zero", mk_instr(lsu_isa_pkg::OP_LBU, 16'd4), 32'd8, 32'h0);
		send("lh sign", mk_instr(lsu_isa_pkg::OP_LH, 16'd4), 32'd8, 32'h0);
		send("lhu zero", mk_instr(lsu_isa_pkg::OP_LHU, 16'd4), 32'd8, 32'h0);
		send("lwl off 1", mk_instr(lsu_isa_pkg::OP_LWL, 16'd5), 32'd8, 32'h0);
		send("lwr off 2", mk_instr(lsu_isa_pkg::OP_LWR, 16'd6), 32'd8, 32'h0);
		send("sh odd", mk_instr(lsu_isa_pkg::OP_SH, 16'd5), 32'd8, 32'h1234);
		send("lw after bad sh", mk_instr(lsu_isa_pkg::OP_LW, 16'd4), 32'd8, 32'h0);

		stall_en = 1'b1;
		for (int n = 0; n < N_RAND; n++) begin
			repeat ($urandom_range(0, 2)) begin // idle gap
				@(posedge clk);
				#1;
			end
			if ($urandom_range(0, 21) < 20)
				op = ops[$urandom_range(0, 9)];
			else
				op = bad_ops[$urandom_range(0, 3)];
			send($sformatf("random %0d op %b", n, op),
				{op, 10'($urandom()), 16'($urandom_range(0, 8 * DEPTH) - 4 * DEPTH)},
				$urandom_range(0, 4 * DEPTH - 1), $urandom());
		end

		drain();
		stall_en = 1'b0;
		@(posedge clk);
		#1;
		send("latency", mk_instr(lsu_isa_pkg::OP_LW, 16'h0), 32'd8, 32'h0);
		lat = 1; // the cycle right after the accept edge is the first
		while (!out_valid && lat < 10) begin
			@(posedge clk);
			#1;
			lat++;
		end
		if (lat != 3) begin
			$display("MISMATCH latency expected %0d actual %0d", 3, lat);
			errors++;
		end
		drain();

		$display("requests %0d responses %0d errors %0d", n_req, n_resp, errors);
		if (errors == 0 && n_resp == n_req)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- mips_lsu.f
+incdir+.
lsu_isa_pkg.sv
lsu_mem_pkg.sv
load_align.sv
lsu_decode.sv
lsu_mem_access.sv
lsu_result.sv
mips_lsu.sv
mips_lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal -j 0
TOP ?= mips_lsu_tb
FILELIST ?= mips_lsu.f
OBJ_DIR ?= obj_dir
PASS_MSG := Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
